// ==== src/prf_config.svh ====
`ifndef PRF_CONFIG_SVH
`define PRF_CONFIG_SVH

// number of physical registers held by the file
`define PRF_SIZE 64

// width of one register value as carried on the result buses
`define PRF_DATA_W 64

// rename grants, result buses, retire frees and retire reads each come in this many
`define PRF_PORTS 2

`endif

// ==== src/prf_alloc_pkg.sv ====
`include "prf_config.svh"

package prf_alloc_pkg;

	////////////////////////////////////////////////////
	// bookkeeping types for the free list

	// index of one physical register, also used as the tag on the result buses
	typedef logic [$clog2(`PRF_SIZE)-1:0] entry_idx_t;

	// one bit per physical register
	// carries the free list, the grants and the release masks
	typedef logic [`PRF_SIZE-1:0] entry_mask_t;

endpackage

// ==== src/prf_data_pkg.sv ====
`include "prf_config.svh"

package prf_data_pkg;

	// one register value
	typedef logic [`PRF_DATA_W-1:0] data_word_t;

	////////////////////////////////////////////////////
	// operand word handed to the reservation station

	// when the operand is valid the word is the register value itself,
	// otherwise the station waits on the tag found in the low bits
	typedef union packed
	{
		data_word_t value;                                       // valid operand view
		struct packed
		{
			logic [`PRF_DATA_W-$bits(prf_alloc_pkg::entry_idx_t)-1:0] pad;   // always zero
			prf_alloc_pkg::entry_idx_t                                idx;   // tag to wait on
		} tag;
	} operand_u;

endpackage

// ==== src/priority_selector.sv ====
`timescale 1ns/1ps

`include "prf_config.svh"

// picks the lowest set request bit and returns it as a one-hot grant
module priority_selector
(
	input  prf_alloc_pkg::entry_mask_t req,
	input  logic                       en,
	output prf_alloc_pkg::entry_mask_t gnt
);

	prf_alloc_pkg::entry_mask_t lowest;   // lowest set bit of req, zero when req is empty

	// two's complement trick keeps only the least significant one
	assign lowest = req & (~req + 1'b1);

	always_comb
	begin
		if (en)
		begin
			gnt = lowest;
		end
		else
		begin
			gnt = '0;   // nothing is granted without a request
		end
	end

endmodule

// ==== src/prf_free_select.sv ====
`timescale 1ns/1ps

`include "prf_config.svh"

// turns the free list into up to two rename grants per cycle
module prf_free_select
(
	input  prf_alloc_pkg::entry_mask_t available_mask,
	input  logic                       alloc_req1,
	input  logic                       alloc_req2,
	output logic                       rename1_valid,
	output prf_alloc_pkg::entry_idx_t  rename1_idx,
	output logic                       rename2_valid,
	output prf_alloc_pkg::entry_idx_t  rename2_idx,
	output prf_alloc_pkg::entry_mask_t grant_mask,
	output logic                       prf_is_full
);

	prf_alloc_pkg::entry_mask_t gnt1;         // one-hot grant for the first request
	prf_alloc_pkg::entry_mask_t gnt2;         // one-hot grant for the second request
	prf_alloc_pkg::entry_mask_t available2;   // free list seen by the second selector

	// encodes a one-hot mask into its index and gives zero for an empty mask
	function automatic prf_alloc_pkg::entry_idx_t onehot_to_idx(
		input prf_alloc_pkg::entry_mask_t oh
	);
		prf_alloc_pkg::entry_idx_t idx;
		idx = '0;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (oh[i])
				idx = idx | prf_alloc_pkg::entry_idx_t'(i);   // only one bit is set so OR is enough
		end
		return idx;
	endfunction

	////////////////////////////////////////////////////
	// chained selectors

	priority_selector sel1_i
	(
		.req (available_mask),
		.en  (alloc_req1),
		.gnt (gnt1)
	);

	// the first grant is taken out so both requests never get the same entry
	// when alloc_req1 is low gnt1 is zero and the whole free list passes through
	assign available2 = available_mask & ~gnt1;

	priority_selector sel2_i
	(
		.req (available2),
		.en  (alloc_req2),
		.gnt (gnt2)
	);

	////////////////////////////////////////////////////
	// grant encoding

	assign rename1_valid = |gnt1;                  // low when not requested or nothing left
	assign rename1_idx   = onehot_to_idx(gnt1);
	assign rename2_valid = |gnt2;
	assign rename2_idx   = onehot_to_idx(gnt2);

	assign grant_mask  = gnt1 | gnt2;              // both grants leave the free list together
	assign prf_is_full = ~|available_mask;         // free list empty

endmodule

// ==== src/prf_release.sv ====
`timescale 1ns/1ps

`include "prf_config.svh"

// collects retirement frees and the mispredict list into one release mask
module prf_release
(
	input  logic                       free1_valid,
	input  prf_alloc_pkg::entry_idx_t  free1_idx,
	input  logic                       free2_valid,
	input  prf_alloc_pkg::entry_idx_t  free2_idx,
	input  logic                       mispredict_free_valid,
	input  prf_alloc_pkg::entry_mask_t mispredict_free_list,
	output prf_alloc_pkg::entry_mask_t free_mask
);

	logic                      free_valid [`PRF_PORTS];   // retire frees gathered per port
	prf_alloc_pkg::entry_idx_t free_idx   [`PRF_PORTS];

	assign free_valid = '{free1_valid, free2_valid};
	assign free_idx   = '{free1_idx, free2_idx};

	always_comb
	begin
		free_mask = '0;
		// each valid retire free releases the entry it names
		for (int p = 0; p < `PRF_PORTS; p++)
		begin
			if (free_valid[p])
				free_mask[free_idx[p]] = 1'b1;
		end
		// a mispredict hands over the whole list and the retire frees are dropped
		if (mispredict_free_valid)
			free_mask = mispredict_free_list;
	end

endmodule

// ==== src/prf_entry_array.sv ====
`timescale 1ns/1ps

`include "prf_config.svh"

// state and data of every physical register
module prf_entry_array
(
	input  logic                       clock,
	input  logic                       rst_n,
	input  prf_alloc_pkg::entry_mask_t grant_mask,   // entries handed to the renamer
	input  prf_alloc_pkg::entry_mask_t free_mask,    // entries going back to the free list
	input  logic                       cdb1_valid,
	input  prf_alloc_pkg::entry_idx_t  cdb1_tag,
	input  prf_data_pkg::data_word_t   cdb1_value,
	input  logic                       cdb2_valid,
	input  prf_alloc_pkg::entry_idx_t  cdb2_tag,
	input  prf_data_pkg::data_word_t   cdb2_value,
	output prf_alloc_pkg::entry_mask_t available_mask,
	output prf_alloc_pkg::entry_mask_t ready_mask,
	output prf_data_pkg::data_word_t   entry_data [`PRF_SIZE]
);

	logic                       cdb_valid [`PRF_PORTS];   // result buses gathered per port
	prf_alloc_pkg::entry_idx_t  cdb_tag   [`PRF_PORTS];
	prf_data_pkg::data_word_t   cdb_value [`PRF_PORTS];

	prf_alloc_pkg::entry_mask_t write_hit;                 // entries written this cycle
	prf_data_pkg::data_word_t   write_value [`PRF_SIZE];   // value each written entry takes

	assign cdb_valid = '{cdb1_valid, cdb2_valid};
	assign cdb_tag   = '{cdb1_tag, cdb2_tag};
	assign cdb_value = '{cdb1_value, cdb2_value};

	////////////////////////////////////////////////////
	// result bus decode

	always_comb
	begin
		write_hit = '0;
		for (int i = 0; i < `PRF_SIZE; i++)
			write_value[i] = '0;
		// later ports overwrite earlier ones so bus 2 wins on a shared tag
		for (int p = 0; p < `PRF_PORTS; p++)
		begin
			if (cdb_valid[p])
			begin
				write_hit[cdb_tag[p]]   = 1'b1;
				write_value[cdb_tag[p]] = cdb_value[p];
			end
		end
	end

	////////////////////////////////////////////////////
	// free list and ready bits

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			available_mask <= '1;   // every entry starts on the free list
			ready_mask     <= '0;
		end
		else
		begin
			for (int i = 0; i < `PRF_SIZE; i++)
			begin
				if (free_mask[i])
				begin
					available_mask[i] <= 1'b1;   // free beats everything else
					ready_mask[i]     <= 1'b0;
				end
				else if (write_hit[i])
				begin
					ready_mask[i] <= 1'b1;       // result has arrived
				end
				else if (grant_mask[i])
				begin
					available_mask[i] <= 1'b0;   // allocated and waiting for its result
					ready_mask[i]     <= 1'b0;
				end
			end
		end
	end

	// register values only move on a result bus write
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (write_hit[i])
				entry_data[i] <= write_value[i];
		end
	end

endmodule

// ==== src/prf_read_ports.sv ====
`timescale 1ns/1ps

`include "prf_config.svh"

// operand and retire reads over the entry array
module prf_read_ports
(
	input  prf_alloc_pkg::entry_mask_t available_mask,
	input  prf_alloc_pkg::entry_mask_t ready_mask,
	input  prf_data_pkg::data_word_t   entry_data [`PRF_SIZE],
	input  prf_alloc_pkg::entry_idx_t  inst1_opa_idx,
	input  prf_alloc_pkg::entry_idx_t  inst1_opb_idx,
	input  prf_alloc_pkg::entry_idx_t  inst2_opa_idx,
	input  prf_alloc_pkg::entry_idx_t  inst2_opb_idx,
	input  prf_alloc_pkg::entry_idx_t  rob1_retire_idx,
	input  prf_alloc_pkg::entry_idx_t  rob2_retire_idx,
	output prf_data_pkg::operand_u     inst1_opa_value,
	output prf_data_pkg::operand_u     inst1_opb_value,
	output prf_data_pkg::operand_u     inst2_opa_value,
	output prf_data_pkg::operand_u     inst2_opb_value,
	output logic                       inst1_opa_valid,
	output logic                       inst1_opb_valid,
	output logic                       inst2_opa_valid,
	output logic                       inst2_opb_valid,
	output prf_data_pkg::data_word_t   writeback_value1,
	output prf_data_pkg::data_word_t   writeback_value2
);

	// an entry holds a usable value once it is allocated and its result is in
	function automatic logic entry_live(
		input prf_alloc_pkg::entry_idx_t  idx,
		input prf_alloc_pkg::entry_mask_t avail,
		input prf_alloc_pkg::entry_mask_t rdy
	);
		return !avail[idx] && rdy[idx];
	endfunction

	// builds the operand word, value view when live, tag view otherwise
	function automatic prf_data_pkg::operand_u make_operand(
		input prf_alloc_pkg::entry_idx_t idx,
		input logic                      live,
		input prf_data_pkg::data_word_t  data
	);
		prf_data_pkg::operand_u op;
		if (live)
		begin
			op.value = data;
		end
		else
		begin
			op.tag.pad = '0;
			op.tag.idx = idx;   // the station waits on this tag
		end
		return op;
	endfunction

	////////////////////////////////////////////////////
	// operand reads

	assign inst1_opa_valid = entry_live(inst1_opa_idx, available_mask, ready_mask);
	assign inst1_opb_valid = entry_live(inst1_opb_idx, available_mask, ready_mask);
	assign inst2_opa_valid = entry_live(inst2_opa_idx, available_mask, ready_mask);
	assign inst2_opb_valid = entry_live(inst2_opb_idx, available_mask, ready_mask);

	assign inst1_opa_value = make_operand(inst1_opa_idx, inst1_opa_valid, entry_data[inst1_opa_idx]);
	assign inst1_opb_value = make_operand(inst1_opb_idx, inst1_opb_valid, entry_data[inst1_opb_idx]);
	assign inst2_opa_value = make_operand(inst2_opa_idx, inst2_opa_valid, entry_data[inst2_opa_idx]);
	assign inst2_opb_value = make_operand(inst2_opb_idx, inst2_opb_valid, entry_data[inst2_opb_idx]);

	////////////////////////////////////////////////////
	// retire reads for the reorder buffer writeback

	// same liveness check as the operands but a dead entry reads as zero
	assign writeback_value1 = entry_live(rob1_retire_idx, available_mask, ready_mask) ?
		entry_data[rob1_retire_idx] : '0;
	assign writeback_value2 = entry_live(rob2_retire_idx, available_mask, ready_mask) ?
		entry_data[rob2_retire_idx] : '0;

endmodule

// ==== src/prf.sv ====
`timescale 1ns/1ps

`include "prf_config.svh"

// physical register file for one renaming thread
module prf
(
	input  logic                       clock,
	input  logic                       rst_n,

	// rename requests and grants
	input  logic                       alloc_req1,
	input  logic                       alloc_req2,
	output logic                       rename1_valid,
	output prf_alloc_pkg::entry_idx_t  rename1_idx,
	output logic                       rename2_valid,
	output prf_alloc_pkg::entry_idx_t  rename2_idx,
	output logic                       prf_is_full,

	// result buses
	input  logic                       cdb1_valid,
	input  prf_alloc_pkg::entry_idx_t  cdb1_tag,
	input  prf_data_pkg::data_word_t   cdb1_value,
	input  logic                       cdb2_valid,
	input  prf_alloc_pkg::entry_idx_t  cdb2_tag,
	input  prf_data_pkg::data_word_t   cdb2_value,

	// operand reads for two instructions
	input  prf_alloc_pkg::entry_idx_t  inst1_opa_idx,
	input  prf_alloc_pkg::entry_idx_t  inst1_opb_idx,
	input  prf_alloc_pkg::entry_idx_t  inst2_opa_idx,
	input  prf_alloc_pkg::entry_idx_t  inst2_opb_idx,
	output prf_data_pkg::operand_u     inst1_opa_value,
	output prf_data_pkg::operand_u     inst1_opb_value,
	output prf_data_pkg::operand_u     inst2_opa_value,
	output prf_data_pkg::operand_u     inst2_opb_value,
	output logic                       inst1_opa_valid,
	output logic                       inst1_opb_valid,
	output logic                       inst2_opa_valid,
	output logic                       inst2_opb_valid,

	// retire reads
	input  prf_alloc_pkg::entry_idx_t  rob1_retire_idx,
	input  prf_alloc_pkg::entry_idx_t  rob2_retire_idx,
	output prf_data_pkg::data_word_t   writeback_value1,
	output prf_data_pkg::data_word_t   writeback_value2,

	// frees on retirement and on a mispredict
	input  logic                       free1_valid,
	input  prf_alloc_pkg::entry_idx_t  free1_idx,
	input  logic                       free2_valid,
	input  prf_alloc_pkg::entry_idx_t  free2_idx,
	input  logic                       mispredict_free_valid,
	input  prf_alloc_pkg::entry_mask_t mispredict_free_list
);

	prf_alloc_pkg::entry_mask_t available_mask;          // free list
	prf_alloc_pkg::entry_mask_t ready_mask;              // result written
	prf_alloc_pkg::entry_mask_t grant_mask;              // both rename grants
	prf_alloc_pkg::entry_mask_t free_mask;               // entries released this cycle
	prf_data_pkg::data_word_t   entry_data [`PRF_SIZE];

	////////////////////////////////////////////////////
	// storage

	prf_entry_array entry_array_i
	(
		.clock          (clock),
		.rst_n          (rst_n),
		.grant_mask     (grant_mask),
		.free_mask      (free_mask),
		.cdb1_valid     (cdb1_valid),
		.cdb1_tag       (cdb1_tag),
		.cdb1_value     (cdb1_value),
		.cdb2_valid     (cdb2_valid),
		.cdb2_tag       (cdb2_tag),
		.cdb2_value     (cdb2_value),
		.available_mask (available_mask),
		.ready_mask     (ready_mask),
		.entry_data     (entry_data)
	);

	////////////////////////////////////////////////////
	// allocation and release

	prf_free_select free_select_i
	(
		.available_mask (available_mask),
		.alloc_req1     (alloc_req1),
		.alloc_req2     (alloc_req2),
		.rename1_valid  (rename1_valid),
		.rename1_idx    (rename1_idx),
		.rename2_valid  (rename2_valid),
		.rename2_idx    (rename2_idx),
		.grant_mask     (grant_mask),
		.prf_is_full    (prf_is_full)
	);

	prf_release release_i
	(
		.free1_valid           (free1_valid),
		.free1_idx             (free1_idx),
		.free2_valid           (free2_valid),
		.free2_idx             (free2_idx),
		.mispredict_free_valid (mispredict_free_valid),
		.mispredict_free_list  (mispredict_free_list),
		.free_mask             (free_mask)
	);

	////////////////////////////////////////////////////
	// reads

	prf_read_ports read_ports_i
	(
		.available_mask   (available_mask),
		.ready_mask       (ready_mask),
		.entry_data       (entry_data),
		.inst1_opa_idx    (inst1_opa_idx),
		.inst1_opb_idx    (inst1_opb_idx),
		.inst2_opa_idx    (inst2_opa_idx),
		.inst2_opb_idx    (inst2_opb_idx),
		.rob1_retire_idx  (rob1_retire_idx),
		.rob2_retire_idx  (rob2_retire_idx),
		.inst1_opa_value  (inst1_opa_value),
		.inst1_opb_value  (inst1_opb_value),
		.inst2_opa_value  (inst2_opa_value),
		.inst2_opb_value  (inst2_opb_value),
		.inst1_opa_valid  (inst1_opa_valid),
		.inst1_opb_valid  (inst1_opb_valid),
		.inst2_opa_valid  (inst2_opa_valid),
		.inst2_opb_valid  (inst2_opb_valid),
		.writeback_value1 (writeback_value1),
		.writeback_value2 (writeback_value2)
	);

endmodule

// ==== testbench/prf_tb_model.svh ====
`ifndef PRF_TB_MODEL_SVH
`define PRF_TB_MODEL_SVH

//////////////////////////////////////////////////
// shadow state of the register file

prf_alloc_pkg::entry_mask_t shadow_avail;                // free list
prf_alloc_pkg::entry_mask_t shadow_ready;                // result written since allocation
prf_data_pkg::data_word_t   shadow_data [`PRF_SIZE];

// index of the lowest set bit, -1 for an empty mask
function automatic int lowest_set(input prf_alloc_pkg::entry_mask_t mask);
	for (int i = 0; i < `PRF_SIZE; i++)
	begin
		if (mask[i])
			return i;
	end
	return -1;
endfunction

// expected rename grants, -1 where no grant is given
function automatic void expect_grants(input logic req1, input logic req2,
	output int g1, output int g2);
	prf_alloc_pkg::entry_mask_t rest;
	g1 = req1 ? lowest_set(shadow_avail) : -1;
	rest = shadow_avail;
	if (g1 >= 0)
		rest[g1] = 1'b0;   // the second request skips the first grant
	g2 = req2 ? lowest_set(rest) : -1;
endfunction

// a mispredict list replaces the retire frees of the same cycle
function automatic prf_alloc_pkg::entry_mask_t expect_free_mask(
	input logic f1, input prf_alloc_pkg::entry_idx_t i1,
	input logic f2, input prf_alloc_pkg::entry_idx_t i2,
	input logic mp, input prf_alloc_pkg::entry_mask_t mp_list);
	prf_alloc_pkg::entry_mask_t mask;
	mask = '0;
	if (f1)
		mask[i1] = 1'b1;
	if (f2)
		mask[i2] = 1'b1;
	return mp ? mp_list : mask;
endfunction

// an entry holds a usable value once it is allocated and written
function automatic logic expect_live(input prf_alloc_pkg::entry_idx_t idx);
	return !shadow_avail[idx] && shadow_ready[idx];
endfunction

// value when live, otherwise the tag zero extended to a full word
function automatic prf_data_pkg::data_word_t expect_operand(input prf_alloc_pkg::entry_idx_t idx);
	if (expect_live(idx))
		return shadow_data[idx];
	return prf_data_pkg::data_word_t'(idx);
endfunction

function automatic prf_data_pkg::data_word_t expect_writeback(
	input prf_alloc_pkg::entry_idx_t idx);
	return expect_live(idx) ? shadow_data[idx] : '0;   // a dead entry reads as zero
endfunction

function automatic void model_reset();
	shadow_avail = '1;
	shadow_ready = '0;
	for (int i = 0; i < `PRF_SIZE; i++)
		shadow_data[i] = '0;
endfunction

// one rising edge, free first, then bus write, then allocation
function automatic void model_step(input prf_alloc_pkg::entry_mask_t gmask,
	input prf_alloc_pkg::entry_mask_t fmask,
	input logic w1, input prf_alloc_pkg::entry_idx_t t1, input prf_data_pkg::data_word_t v1,
	input logic w2, input prf_alloc_pkg::entry_idx_t t2, input prf_data_pkg::data_word_t v2);
	prf_alloc_pkg::entry_mask_t hit;
	hit = '0;
	if (w1)
	begin
		hit[t1] = 1'b1;
		shadow_data[t1] = v1;
	end
	if (w2)
	begin
		hit[t2] = 1'b1;
		shadow_data[t2] = v2;   // written last so bus 2 wins a shared tag
	end
	for (int i = 0; i < `PRF_SIZE; i++)
	begin
		if (fmask[i])
		begin
			shadow_avail[i] = 1'b1;
			shadow_ready[i] = 1'b0;
		end
		else if (hit[i])
			shadow_ready[i] = 1'b1;
		else if (gmask[i])
		begin
			shadow_avail[i] = 1'b0;
			shadow_ready[i] = 1'b0;
		end
	end
endfunction

`endif

// ==== testbench/prf_tb.sv ====
`timescale 1ns/1ps

`include "prf_config.svh"

module prf_tb;

	localparam int CLOCK_PERIOD    = 20;
	localparam int DIRECTED_CYCLES = 80;    // upper bound for the directed part
	localparam int RANDOM_CYCLES   = 400;
	localparam int TIMEOUT_NS      = (DIRECTED_CYCLES + RANDOM_CYCLES + 50) * CLOCK_PERIOD;

	localparam prf_data_pkg::data_word_t VALUE_A = 64'h0123_4567_89ab_cdef;
	localparam prf_data_pkg::data_word_t VALUE_B = 64'hdead_beef_0000_1111;
	localparam prf_data_pkg::data_word_t VALUE_C = 64'h5555_aaaa_1234_5678;
	localparam prf_data_pkg::data_word_t VALUE_D = 64'h0f0f_0f0f_f0f0_f0f0;

	logic clock = 1'b0;
	logic rst_n;
	logic alloc_req1, alloc_req2;
	logic rename1_valid, rename2_valid, prf_is_full;
	prf_alloc_pkg::entry_idx_t  rename1_idx, rename2_idx;
	logic cdb1_valid, cdb2_valid;
	prf_alloc_pkg::entry_idx_t  cdb1_tag, cdb2_tag;
	prf_data_pkg::data_word_t   cdb1_value, cdb2_value;
	prf_alloc_pkg::entry_idx_t  inst1_opa_idx, inst1_opb_idx, inst2_opa_idx, inst2_opb_idx;
	prf_data_pkg::operand_u     inst1_opa_value, inst1_opb_value, inst2_opa_value, inst2_opb_value;
	logic inst1_opa_valid, inst1_opb_valid, inst2_opa_valid, inst2_opb_valid;
	prf_alloc_pkg::entry_idx_t  rob1_retire_idx, rob2_retire_idx;
	prf_data_pkg::data_word_t   writeback_value1, writeback_value2;
	logic free1_valid, free2_valid, mispredict_free_valid;
	prf_alloc_pkg::entry_idx_t  free1_idx, free2_idx;
	prf_alloc_pkg::entry_mask_t mispredict_free_list;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] rand_state = 32'h76035877;

	`include "prf_tb_model.svh"

	prf prf_i (.*);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	function automatic logic [31:0] lcg_next();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// the low bits of the generator repeat quickly so the index takes the high ones
	function automatic prf_alloc_pkg::entry_idx_t rand_idx();
		return prf_alloc_pkg::entry_idx_t'(lcg_next() >> 20);
	endfunction

	function automatic logic [63:0] rand_word();
		return {lcg_next(), lcg_next()};
	endfunction

	task automatic compare_value(input string name, input logic [`PRF_DATA_W-1:0] actual,
		input logic [`PRF_DATA_W-1:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus helpers

	task automatic init_inputs();
		{alloc_req1, alloc_req2, cdb1_valid, cdb2_valid} = '0;
		{cdb1_tag, cdb2_tag, cdb1_value, cdb2_value} = '0;
		{inst1_opa_idx, inst1_opb_idx, inst2_opa_idx, inst2_opb_idx} = '0;
		{rob1_retire_idx, rob2_retire_idx} = '0;
		{free1_valid, free2_valid, free1_idx, free2_idx} = '0;
		mispredict_free_valid = 1'b0;
		mispredict_free_list  = '0;
	endtask

	// strobes drop back to idle on every falling edge while the read indices hold
	task automatic next_cycle();
		@(negedge clock);
		{alloc_req1, alloc_req2, cdb1_valid, cdb2_valid} = '0;
		{free1_valid, free2_valid, mispredict_free_valid} = '0;
	endtask

	//////////////////////////////////////////////////
	// directed tests

	task automatic after_reset_test();
		next_cycle();
		alloc_req2 = 1'b1;   // alone it takes the lowest entry
		#5;
		compare_value("prf_is_full", prf_is_full, 1'b0);
		compare_value("rename1_valid", rename1_valid, 1'b0);
		compare_value("rename2_valid", rename2_valid, 1'b1);
		compare_value("rename2_idx", rename2_idx, 0);
		next_cycle();
		free1_valid = 1'b1;
		free1_idx   = 0;
		next_cycle();
		{alloc_req1, alloc_req2} = 2'b11;
		#5;
		compare_value("rename1_idx", rename1_idx, 0);
		compare_value("rename2_idx", rename2_idx, 1);
	endtask

	task automatic fill_test();
		int last;
		last = 1;   // entries 0 and 1 are already taken
		for (int c = 0; c < 40 && !prf_is_full; c++)
		begin
			next_cycle();
			{alloc_req1, alloc_req2} = 2'b11;
			#5;
			if (rename1_valid && rename1_idx <= last)
			begin
				errors++;
				$display("error rename1_idx %h not above previous index %h", rename1_idx, last);
			end
			if (rename1_valid)
				last = rename1_idx;
			if (rename2_valid && rename2_idx <= last)
			begin
				errors++;
				$display("error rename2_idx %h not above previous index %h", rename2_idx, last);
			end
			if (rename2_valid)
				last = rename2_idx;
		end
		if (last != `PRF_SIZE - 1)
		begin
			errors++;
			$display("filling stopped at entry %0d before the last entry", last);
		end
		compare_value("prf_is_full", prf_is_full, 1'b1);
		compare_value("rename1_valid", rename1_valid, 1'b0);
		compare_value("rename2_valid", rename2_valid, 1'b0);
	endtask

	task automatic bus_write_test();
		next_cycle();
		inst1_opa_idx = 5;
		#5;
		compare_value("inst1_opa_valid", inst1_opa_valid, 1'b0);
		compare_value("inst1_opa_value", inst1_opa_value, 5);   // tag view
		next_cycle();
		{cdb1_valid, cdb1_tag, cdb1_value} = {1'b1, 6'd5, VALUE_A};
		next_cycle();
		{cdb1_valid, cdb1_tag, cdb1_value} = {1'b1, 6'd9, VALUE_B};
		{cdb2_valid, cdb2_tag, cdb2_value} = {1'b1, 6'd9, VALUE_C};
		#5;
		compare_value("inst1_opa_valid", inst1_opa_valid, 1'b1);
		compare_value("inst1_opa_value", inst1_opa_value, VALUE_A);
		next_cycle();
		inst2_opb_idx = 9;
		#5;
		compare_value("inst2_opb_valid", inst2_opb_valid, 1'b1);
		compare_value("inst2_opb_value", inst2_opb_value, VALUE_C);
	endtask

	task automatic retire_read_test();
		next_cycle();
		rob1_retire_idx = 5;
		rob2_retire_idx = 10;   // allocated but never written
		{cdb1_valid, cdb1_tag, cdb1_value} = {1'b1, 6'd12, VALUE_D};
		#5;
		compare_value("writeback_value1", writeback_value1, VALUE_A);
		compare_value("writeback_value2", writeback_value2, 0);
		next_cycle();
		free1_valid = 1'b1;
		free1_idx   = 5;
		next_cycle();
		#5;
		compare_value("writeback_value1", writeback_value1, 0);
	endtask

	task automatic free_test();
		prf_alloc_pkg::entry_mask_t mask;
		prf_alloc_pkg::entry_mask_t now_free;
		next_cycle();
		free1_valid = 1'b1;
		free1_idx   = 3;
		next_cycle();
		alloc_req1 = 1'b1;
		#5;
		compare_value("rename1_idx", rename1_idx, 3);   // 3 sits below the free entry 5
		next_cycle();
		mask     = prf_alloc_pkg::entry_mask_t'(rand_word());
		mask[9]  = 1'b0;
		mask[12] = 1'b1;
		mispredict_free_valid = 1'b1;
		mispredict_free_list  = mask;
		free1_valid = 1'b1;   // must be ignored under the mispredict
		free1_idx   = 9;
		next_cycle();
		inst1_opa_idx = 9;
		inst1_opb_idx = 12;
		alloc_req1    = 1'b1;
		now_free      = mask;
		now_free[5]   = 1'b1;
		#5;
		compare_value("inst1_opa_valid", inst1_opa_valid, 1'b1);
		compare_value("inst1_opa_value", inst1_opa_value, VALUE_C);
		compare_value("inst1_opb_valid", inst1_opb_valid, 1'b0);
		compare_value("inst1_opb_value", inst1_opb_value, 12);
		compare_value("rename1_idx", rename1_idx, lowest_set(now_free));
	endtask

	task automatic random_run(input int cycles);
		logic [31:0] r;
		for (int c = 0; c < cycles; c++)
		begin
			next_cycle();
			r = lcg_next();
			{alloc_req1, alloc_req2, cdb1_valid, cdb2_valid} = r[31:28];
			free1_valid = r[27] & r[26];
			free2_valid = r[25] & r[24];
			mispredict_free_valid = (r[23:19] == 0);   // about one cycle in 32
			{cdb1_tag, cdb2_tag} = {rand_idx(), rand_idx()};
			{free1_idx, free2_idx} = {rand_idx(), rand_idx()};
			cdb1_value = rand_word();
			cdb2_value = rand_word();
			{inst1_opa_idx, inst1_opb_idx, inst2_opa_idx} = {rand_idx(), rand_idx(), rand_idx()};
			{inst2_opb_idx, rob1_retire_idx, rob2_retire_idx} = {rand_idx(), rand_idx(), rand_idx()};
			mispredict_free_list = rand_word();
		end
	endtask

	//////////////////////////////////////////////////
	// comparison against the model

	task automatic compare_outputs();
		int g1;
		int g2;
		expect_grants(alloc_req1, alloc_req2, g1, g2);
		compare_value("rename1_valid", rename1_valid, g1 >= 0);
		compare_value("rename1_idx", rename1_idx, (g1 >= 0) ? g1 : 0);
		compare_value("rename2_valid", rename2_valid, g2 >= 0);
		compare_value("rename2_idx", rename2_idx, (g2 >= 0) ? g2 : 0);
		compare_value("prf_is_full", prf_is_full, shadow_avail == '0);
		compare_value("inst1_opa_valid", inst1_opa_valid, expect_live(inst1_opa_idx));
		compare_value("inst1_opb_valid", inst1_opb_valid, expect_live(inst1_opb_idx));
		compare_value("inst2_opa_valid", inst2_opa_valid, expect_live(inst2_opa_idx));
		compare_value("inst2_opb_valid", inst2_opb_valid, expect_live(inst2_opb_idx));
		compare_value("inst1_opa_value", inst1_opa_value, expect_operand(inst1_opa_idx));
		compare_value("inst1_opb_value", inst1_opb_value, expect_operand(inst1_opb_idx));
		compare_value("inst2_opa_value", inst2_opa_value, expect_operand(inst2_opa_idx));
		compare_value("inst2_opb_value", inst2_opb_value, expect_operand(inst2_opb_idx));
		compare_value("writeback_value1", writeback_value1, expect_writeback(rob1_retire_idx));
		compare_value("writeback_value2", writeback_value2, expect_writeback(rob2_retire_idx));
	endtask

	task automatic advance_model();
		int g1;
		int g2;
		prf_alloc_pkg::entry_mask_t gmask;
		expect_grants(alloc_req1, alloc_req2, g1, g2);
		gmask = '0;
		if (g1 >= 0)
			gmask[g1] = 1'b1;
		if (g2 >= 0)
			gmask[g2] = 1'b1;
		model_step(gmask,
			expect_free_mask(free1_valid, free1_idx, free2_valid, free2_idx,
				mispredict_free_valid, mispredict_free_list),
			cdb1_valid, cdb1_tag, cdb1_value, cdb2_valid, cdb2_tag, cdb2_value);
	endtask

	initial
	begin
		forever
		begin
			@(negedge clock);
			#(CLOCK_PERIOD / 2 - 1);   // just before the rising edge
			if (rst_n)
				compare_outputs();
			@(posedge clock);
			if (!rst_n)
				model_reset();
			else
				advance_model();
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		rst_n = 1'b0;
		init_inputs();
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		after_reset_test();
		fill_test();
		bus_write_test();
		retire_read_test();
		free_test();
		random_run(RANDOM_CYCLES);
		next_cycle();
		@(negedge clock);   // the last driven cycle has been compared by now
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+src
+incdir+testbench
src/prf_alloc_pkg.sv
src/prf_data_pkg.sv
src/priority_selector.sv
src/prf_free_select.sv
src/prf_release.sv
src/prf_entry_array.sv
src/prf_read_ports.sv
src/prf.sv
testbench/prf_tb.sv

// ==== Bender.yml ====
package:
  name: prf

sources:
  - include_dirs:
      - src
    files:
      - src/prf_alloc_pkg.sv
      - src/prf_data_pkg.sv
      - src/priority_selector.sv
      - src/prf_free_select.sv
      - src/prf_release.sv
      - src/prf_entry_array.sv
      - src/prf_read_ports.sv
      - src/prf.sv
  - target: test
    include_dirs:
      - src
      - testbench
    files:
      - testbench/prf_tb.sv
